// ==== alu.sv ====
module alu import rvPkg::*; (
    input  aluOpE           aluOp_i,
    input  logic [XLEN-1:0] srcA_i,
    input  logic [XLEN-1:0] srcB_i,
    output logic [XLEN-1:0] result_o,
    output logic            zero_o,
    output logic            less_o
);

    logic [SHAMT_W-1:0] shamt;
    logic               lessSigned;
    logic               lessUnsigned;

    assign shamt        = srcB_i[SHAMT_W-1:0];
    assign lessSigned   = $signed(srcA_i) < $signed(srcB_i);
    assign lessUnsigned = srcA_i < srcB_i;

    // unsigned compare only for SLTU, branches pick the op to match
    assign less_o = (aluOp_i == ALU_SLTU) ? lessUnsigned : lessSigned;

    always_comb begin
        case (aluOp_i)
            ALU_ADD:   result_o = srcA_i + srcB_i;
            ALU_SUB:   result_o = srcA_i - srcB_i;
            ALU_SLL:   result_o = srcA_i << shamt;
            ALU_SLT:   result_o = {{(XLEN-1){1'b0}}, lessSigned};
            ALU_SLTU:  result_o = {{(XLEN-1){1'b0}}, lessUnsigned};
            ALU_XOR:   result_o = srcA_i ^ srcB_i;
            ALU_SRL:   result_o = srcA_i >> shamt;
            ALU_SRA:   result_o = $unsigned($signed(srcA_i) >>> shamt);
            ALU_OR:    result_o = srcA_i | srcB_i;
            ALU_AND:   result_o = srcA_i & srcB_i;
            ALU_PASSB: result_o = srcB_i;
            default:   result_o = '0;
        endcase
    end

    assign zero_o = (result_o == '0);

endmodule

// ==== immGen.sv ====
module immGen import rvPkg::*; (
    input  logic [XLEN-1:0] instr_i,
    input  immFmtE          immFmt_i,
    output logic [XLEN-1:0] imm_o
);

    logic sign;

    assign sign = instr_i[31];

    always_comb begin
        case (immFmt_i)
            IMM_I: imm_o = {{20{sign}}, instr_i[31:20]};
            IMM_S: imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            // branch offset, bit 0 implied zero
            IMM_B: imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                            instr_i[11:8], 1'b0};
            IMM_U: imm_o = {instr_i[31:12], 12'b0};
            // jump offset, bit 0 implied zero
            IMM_J: imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                            instr_i[30:21], 1'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

// ==== instrDecoder.sv ====
module instrDecoder import rvPkg::*; (
    input  logic [XLEN-1:0]       instr_i,
    output logic [REG_ADDR_W-1:0] rs1Addr_o,
    output logic [REG_ADDR_W-1:0] rs2Addr_o,
    output logic [REG_ADDR_W-1:0] rdAddr_o,
    output ctrlS                  ctrl_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign rdAddr_o  = instr_i[11:7];
    assign rs1Addr_o = instr_i[19:15];
    assign rs2Addr_o = instr_i[24:20];

    // alt picks SUB over ADD and SRA over SRL
    function automatic aluOpE aluFromFunct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        // no-op unless an opcode below matches
        ctrl_o           = '0;
        ctrl_o.srcBSel   = SRCB_RS2;
        ctrl_o.aluOp     = ALU_ADD;
        ctrl_o.immFmt    = IMM_I;
        ctrl_o.branch    = BR_NONE;

        case (opcode)
            OPC_LUI: begin
                ctrl_o.regWrEn = 1'b1;
                ctrl_o.srcBSel = SRCB_IMM;
                ctrl_o.aluOp   = ALU_PASSB;
                ctrl_o.immFmt  = IMM_U;
            end
            OPC_AUIPC: begin
                ctrl_o.regWrEn = 1'b1;
                ctrl_o.srcAPc  = 1'b1;
                ctrl_o.srcBSel = SRCB_IMM;
                ctrl_o.immFmt  = IMM_U;
            end
            OPC_JAL, OPC_JALR: begin
                // link value is pc + 4
                ctrl_o.regWrEn = 1'b1;
                ctrl_o.srcAPc  = 1'b1;
                ctrl_o.srcBSel = SRCB_FOUR;
                ctrl_o.immFmt  = (opcode == OPC_JAL) ? IMM_J : IMM_I;
                ctrl_o.branch  = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
            end
            OPC_BRANCH: begin
                ctrl_o.immFmt = IMM_B;
                case (funct3)
                    3'b000: begin ctrl_o.branch = BR_EQ;  ctrl_o.aluOp = ALU_SUB;  end
                    3'b001: begin ctrl_o.branch = BR_NE;  ctrl_o.aluOp = ALU_SUB;  end
                    3'b100: begin ctrl_o.branch = BR_LT;  ctrl_o.aluOp = ALU_SLT;  end
                    3'b101: begin ctrl_o.branch = BR_GE;  ctrl_o.aluOp = ALU_SLT;  end
                    3'b110: begin ctrl_o.branch = BR_LTU; ctrl_o.aluOp = ALU_SLTU; end
                    3'b111: begin ctrl_o.branch = BR_GEU; ctrl_o.aluOp = ALU_SLTU; end
                    default: ctrl_o.branch = BR_NONE;
                endcase
            end
            OPC_LOAD: begin
                ctrl_o.regWrEn   = 1'b1;
                ctrl_o.wbFromMem = 1'b1;
                ctrl_o.srcBSel   = SRCB_IMM;
            end
            OPC_STORE: begin
                ctrl_o.memWr   = 1'b1;
                ctrl_o.srcBSel = SRCB_IMM;
                ctrl_o.immFmt  = IMM_S;
            end
            OPC_OPIMM: begin
                // only the shift-right immediates use funct7
                ctrl_o.regWrEn = 1'b1;
                ctrl_o.srcBSel = SRCB_IMM;
                ctrl_o.aluOp   = aluFromFunct(funct3, (funct3 == 3'b101) && funct7[5]);
            end
            OPC_OP: begin
                ctrl_o.regWrEn = 1'b1;
                ctrl_o.aluOp   = aluFromFunct(funct3, funct7[5]);
            end
            default: ;
        endcase
    end

endmodule

// ==== pcUnit.sv ====
module pcUnit import rvPkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  branchE          branch_i,
    input  logic            zero_i,
    input  logic            less_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] rs1Data_i,
    output logic [XLEN-1:0] curPc_o,
    output logic [XLEN-1:0] nextPc_o
);

    logic            taken;
    logic [XLEN-1:0] jalrTarget;

    // condition from the flags of the compare the decoder chose
    always_comb begin
        case (branch_i)
            BR_JAL:          taken = 1'b1;
            BR_EQ:           taken = zero_i;
            BR_NE:           taken = ~zero_i;
            BR_LT, BR_LTU:   taken = less_i;
            BR_GE, BR_GEU:   taken = ~less_i;
            default:         taken = 1'b0;
        endcase
    end

    assign jalrTarget = rs1Data_i + imm_i;

    always_comb begin
        if (!rst_n) begin
            // fetch restarts at address 0
            nextPc_o = '0;
        end else if (branch_i == BR_JALR) begin
            nextPc_o = {jalrTarget[XLEN-1:1], 1'b0};
        end else if (taken) begin
            nextPc_o = curPc_o + imm_i;
        end else begin
            nextPc_o = curPc_o + XLEN'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            curPc_o <= '0;
        end else begin
            curPc_o <= nextPc_o;
        end
    end

endmodule

// ==== regFile.sv ====
module regFile import rvPkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] rs1Addr_i,
    input  logic [REG_ADDR_W-1:0] rs2Addr_i,
    input  logic [REG_ADDR_W-1:0] rdAddr_i,
    input  logic [XLEN-1:0]       rdData_i,
    input  logic                  wrEn_i,
    output logic [XLEN-1:0]       rs1Data_o,
    output logic [XLEN-1:0]       rs2Data_o
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            doWrite;

    // x0 is never written
    assign doWrite = rst_n && wrEn_i && (rdAddr_i != '0);

    always_ff @(posedge clk) begin
        if (doWrite) begin
            regs[rdAddr_i] <= rdData_i;
        end
    end

    // combinational reads, x0 reads zero
    assign rs1Data_o = (rs1Addr_i == '0) ? '0 : regs[rs1Addr_i];
    assign rs2Data_o = (rs2Addr_i == '0) ? '0 : regs[rs2Addr_i];

endmodule

// ==== run.sh ====
#!/bin/sh
# build the RV32I core testbench with Verilator, run it and scan the log
verilator --binary --timing --top-module tbRvCore -f vlog.f -o simRvCore \
    && ./obj_dir/simRvCore > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

// ==== rvCore.sv ====
module rvCore import rvPkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [XLEN-1:0] instr_i,
    output logic [XLEN-1:0] instrAddr_o,
    output logic [XLEN-1:0] dmemAddr_o,
    output logic [XLEN-1:0] dmemWData_o,
    output logic            dmemWr_o,
    input  logic [XLEN-1:0] dmemRData_i
);

    ctrlS                  ctrl;
    logic [REG_ADDR_W-1:0] rs1Addr;
    logic [REG_ADDR_W-1:0] rs2Addr;
    logic [REG_ADDR_W-1:0] rdAddr;
    logic [XLEN-1:0]       rs1Data;
    logic [XLEN-1:0]       rs2Data;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       srcA;
    logic [XLEN-1:0]       srcB;
    logic [XLEN-1:0]       aluResult;
    logic                  zero;
    logic                  less;
    logic [XLEN-1:0]       curPc;
    logic [XLEN-1:0]       wbData;
    logic                  regWrEn;

    instrDecoder instrDecoder_i (
        .instr_i   (instr_i),
        .rs1Addr_o (rs1Addr),
        .rs2Addr_o (rs2Addr),
        .rdAddr_o  (rdAddr),
        .ctrl_o    (ctrl)
    );

    immGen immGen_i (.instr_i(instr_i), .immFmt_i(ctrl.immFmt), .imm_o(imm));

    // operand muxes
    assign srcA = ctrl.srcAPc ? curPc : rs1Data;
    assign srcB = (ctrl.srcBSel == SRCB_FOUR) ? XLEN'(4) :
                  (ctrl.srcBSel == SRCB_IMM)  ? imm : rs2Data;

    alu alu_i (.aluOp_i(ctrl.aluOp), .srcA_i(srcA), .srcB_i(srcB),
               .result_o(aluResult), .zero_o(zero), .less_o(less));

    // write-back and writes held off while in reset
    assign wbData  = ctrl.wbFromMem ? dmemRData_i : aluResult;
    assign regWrEn = ctrl.regWrEn & rst_n;

    regFile regFile_i (
        .clk       (clk),       .rst_n     (rst_n),
        .rs1Addr_i (rs1Addr),   .rs2Addr_i (rs2Addr),
        .rdAddr_i  (rdAddr),    .rdData_i  (wbData),
        .wrEn_i    (regWrEn),   .rs1Data_o (rs1Data),
        .rs2Data_o (rs2Data)
    );

    pcUnit pcUnit_i (
        .clk       (clk),       .rst_n     (rst_n),
        .branch_i  (ctrl.branch), .zero_i  (zero),
        .less_i    (less),      .imm_i     (imm),
        .rs1Data_i (rs1Data),   .curPc_o   (curPc),
        .nextPc_o  (instrAddr_o)
    );

    // data memory side
    assign dmemAddr_o  = aluResult;
    assign dmemWData_o = rs2Data;
    assign dmemWr_o    = ctrl.memWr & rst_n;

endmodule

// ==== rvPkg.sv ====
package rvPkg;

    // datapath and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;
    localparam int SHAMT_W    = $clog2(XLEN);

    // operand B selects
    localparam logic [1:0] SRCB_RS2  = 2'd0;
    localparam logic [1:0] SRCB_IMM  = 2'd1;
    localparam logic [1:0] SRCB_FOUR = 2'd2;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OPIMM  = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcodeE;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        // forwards operand B, used by LUI
        ALU_PASSB = 4'd10
    } aluOpE;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } immFmtE;

    // nine kinds, so four bits
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_JAL  = 4'd1,
        BR_JALR = 4'd2,
        BR_EQ   = 4'd3,
        BR_NE   = 4'd4,
        BR_LT   = 4'd5,
        BR_GE   = 4'd6,
        BR_LTU  = 4'd7,
        BR_GEU  = 4'd8
    } branchE;

    // decoded control word for one instruction
    typedef struct packed {
        logic       regWrEn;
        logic       memWr;
        logic       wbFromMem;
        logic       srcAPc;
        logic [1:0] srcBSel;
        aluOpE      aluOp;
        immFmtE     immFmt;
        branchE     branch;
    } ctrlS;

endpackage

// ==== tbRvCore.sv ====
module tbRvCore import rvPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS    = 13;
    localparam int RESET_CYCLES = 10;
    localparam int STORE_WAIT   = 20;
    localparam int MAX_CYCLES   = NUM_TESTS * (RESET_CYCLES + STORE_WAIT) + 50;
    localparam logic [XLEN-1:0] NOP = 32'h0000_0013;

    logic            clk;
    logic            rst_n = 1'b0;
    logic [XLEN-1:0] instr = NOP;
    logic [XLEN-1:0] instrAddr;
    logic [XLEN-1:0] dmemAddr;
    logic [XLEN-1:0] dmemWData;
    logic            dmemWr;
    logic [XLEN-1:0] dmemRData;
    logic [XLEN-1:0] imem [64];
    logic [XLEN-1:0] dmem [64] = '{default: '0};
    int              errors = 0;
    int              failedTests = 0;
    int              cycles = 0;

    // branch tests hold the taken branch at word 2 and the not-taken one at word 4
    // x0_reset opens with a store, which sits at the fetch address throughout reset
    logic [XLEN-1:0] progs [NUM_TESTS][8] = '{
        '{32'hff900093, 32'h00c00113, 32'h002081b3, 32'h40118233,
          32'h001272b3, 32'h0032e333, 32'h001343b3, 32'h00702423},
        '{32'hff000093, 32'h00400113, 32'h4020d1b3, 32'h0021d233,
          32'h002212b3, 32'h00328333, 32'h00602623, NOP},
        '{32'hff000093, 32'h00400113, 32'h0020a1b3, 32'h0020b233,
          32'h002192b3, 32'h0042e333, 32'h00602823, NOP},
        '{32'hdeadc0b7, 32'heef08093, 32'h00001117, 32'h002081b3,
          32'hf001c213, 32'h00402a23, NOP, NOP},
        '{32'h12300093, 32'h02000293, 32'h0012a223, 32'h0042a103,
          32'hffd10193, 32'hfe32ac23, NOP, NOP},
        '{32'h00500093, 32'h00500113, 32'h00208463, 32'h01008093,
          32'h00209463, 32'h00108093, 32'h02102823, NOP},
        '{32'h00500093, 32'h00700113, 32'h00209463, 32'h01008093,
          32'h00208463, 32'h00108093, 32'h02102823, NOP},
        '{32'hffd00093, 32'h00200113, 32'h0020c463, 32'h01008093,
          32'h0020d463, 32'h00108093, 32'h02102823, NOP},
        '{32'h00200093, 32'hffd00113, 32'h0020d463, 32'h01008093,
          32'h0020c463, 32'h00108093, 32'h02102823, NOP},
        '{32'h00200093, 32'hffd00113, 32'h0020e463, 32'h01008093,
          32'h0020f463, 32'h00108093, 32'h02102823, NOP},
        '{32'hffd00093, 32'h00200113, 32'h0020f463, 32'h01008093,
          32'h0020e463, 32'h00108093, 32'h02102823, NOP},
        '{32'h008000ef, 32'h04008093, 32'h00d08167, 32'h04010113,
          32'h002081b3, 32'h00000217, 32'h004181b3, 32'h02302423},
        '{32'h02002623, 32'h07b00013, 32'h02002623, NOP, NOP, NOP, NOP, NOP}
    };
    string names [NUM_TESTS] = '{"alu_logic", "shifts", "compare", "imm_forms",
        "load_store", "beq_taken", "bne_taken", "blt_taken", "bge_taken",
        "bltu_taken", "bgeu_taken", "jal_jalr", "x0_reset"};
    // load_store and x0_reset check their second store
    int skipStores [NUM_TESTS] = '{0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 1};
    logic [XLEN-1:0] expAddr [NUM_TESTS] = '{32'h08, 32'h0c, 32'h10, 32'h14, 32'h18,
        32'h30, 32'h30, 32'h30, 32'h30, 32'h30, 32'h30, 32'h28, 32'h2c};
    logic [XLEN-1:0] expData [NUM_TESTS] = '{32'hffff_fff4, 32'hffff_ffef, 32'h10,
        32'h2152_31f7, 32'h120, 32'h6, 32'h6, 32'hffff_fffe, 32'h3, 32'h3,
        32'hffff_fffe, 32'h24, 32'h0};

    rvCore rvCore_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_i     (instr),
        .instrAddr_o (instrAddr),
        .dmemAddr_o  (dmemAddr),
        .dmemWData_o (dmemWData),
        .dmemWr_o    (dmemWr),
        .dmemRData_i (dmemRData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // synchronous instruction memory returns the word one cycle after the address
    always @(posedge clk) begin
        instr <= imem[instrAddr[7:2]];
    end

    assign dmemRData = dmem[dmemAddr[7:2]];

    always @(posedge clk) begin
        if (dmemWr) begin
            dmem[dmemAddr[7:2]] <= dmemWData;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check(input string what, input logic [XLEN-1:0] expVal,
                         input logic [XLEN-1:0] actVal);
        if (actVal !== expVal) begin
            $display("FAILED %s: expected %h, actual %h", what, expVal, actVal);
            errors++;
        end
    endtask

    // inputs change 1 ns after the edge and outputs are sampled 1 ns later
    task automatic runTest(input int t);
        int   stores;
        int   waited;
        int   errBefore;
        logic seen;
        errBefore = errors;
        stores = 0;
        seen = 1'b0;
        rst_n = 1'b0;
        for (int k = 0; k < 64; k++) begin
            imem[k] = NOP;
        end
        for (int k = 0; k < 8; k++) begin
            imem[k] = progs[t][k];
        end
        repeat (RESET_CYCLES) begin
            #1;
            check({names[t], " reset fetch address"}, '0, instrAddr);
            check({names[t], " reset store strobe"}, '0, {31'b0, dmemWr});
            @(posedge clk);
            #1;
        end
        rst_n = 1'b1;
        for (waited = 0; waited < STORE_WAIT && !seen; waited++) begin
            #1;
            if (dmemWr) begin
                if (stores == skipStores[t]) begin
                    check({names[t], " store address"}, expAddr[t], dmemAddr);
                    check({names[t], " store data"}, expData[t], dmemWData);
                    seen = 1'b1;
                end
                stores++;
            end
            @(posedge clk);
            #1;
        end
        if (!seen) begin
            $display("%s: no store seen within %0d cycles", names[t], STORE_WAIT);
            errors++;
        end
        if (errors != errBefore) begin
            failedTests++;
        end
        $display("test %s: %s", names[t], (errors == errBefore) ? "passed" : "failed");
    endtask

    initial begin
        @(posedge clk);
        #1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
        end
        $display("tests: %0d, passed: %0d, failed: %0d, errors: %0d", NUM_TESTS,
                 NUM_TESTS - failedTests, failedTests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rvPkg.sv
instrDecoder.sv
immGen.sv
alu.sv
regFile.sv
pcUnit.sv
rvCore.sv
tbRvCore.sv
